/* hdl/la_pkg.sv */
package la_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Trigger mode
    //////////////////////////////////////////////////////////////////////////////

    // Selects how the capture controller combines the two trigger hits
    typedef enum logic [1:0]
    {
        TRIG_EDGE    = 2'b00,
        TRIG_PATTERN = 2'b01,
        TRIG_BOTH    = 2'b10,
        TRIG_EITHER  = 2'b11
    } trig_mode_t;

    //////////////////////////////////////////////////////////////////////////////
    // Per-channel trigger rules
    //////////////////////////////////////////////////////////////////////////////

    // One channel against its selected edge since the previous valid sample
    function automatic logic edge_agree
    (
        input logic rise_sel,
        input logic fall_sel,
        input logic prev_bit,
        input logic cur_bit
    );
        logic agree;
        case ({rise_sel, fall_sel})
            // Unselected channel never blocks the trigger
            2'b00:   agree = 1'b1;
            2'b10:   agree = !prev_bit && cur_bit;
            2'b01:   agree = prev_bit && !cur_bit;
            // Both selects accept any change
            default: agree = prev_bit ^ cur_bit;
        endcase
        return agree;
    endfunction

    // One channel against the pattern, masked bits always match
    function automatic logic pattern_bit_match
    (
        input logic care_bit,
        input logic value_bit,
        input logic cur_bit
    );
        return !care_bit || (cur_bit == value_bit);
    endfunction

endpackage

/* hdl/edge_trigger.sv */
`timescale 1ns/1ps

module edge_trigger
    import la_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 8
)
(
    input  logic                    clock,
    input  logic                    arm,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample_data,
    input  logic [SAMPLE_WIDTH-1:0] rise_select,
    input  logic [SAMPLE_WIDTH-1:0] fall_select,
    output logic                    edge_hit
);

    //////////////////////////////////////////////////////////////////////////////
    // Sample history
    //////////////////////////////////////////////////////////////////////////////

    // Last valid sample seen since arm
    logic [SAMPLE_WIDTH-1:0] prev_sample;
    // Set once the first valid sample after arm has been stored
    logic                    have_prev;
    // Per-channel agreement with the selected edge
    logic [SAMPLE_WIDTH-1:0] agree;

    // History moves only on valid samples
    // Idle cycles between samples do not count as transitions
    always_ff @(posedge clock)
    begin
        if (sample_valid)
        begin
            prev_sample <= sample_data;
        end
    end

    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            have_prev <= 1'b0;
        end
        else if (sample_valid)
        begin
            have_prev <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Edge detection
    //////////////////////////////////////////////////////////////////////////////

    // Each channel compares itself to its own previous value
    always_comb
    begin
        for (int i = 0; i < SAMPLE_WIDTH; i++)
        begin
            agree[i] = edge_agree(rise_select[i], fall_select[i],
                                  prev_sample[i], sample_data[i]);
        end
    end

    // All channels must agree on the same sample
    // First sample after arm has nothing to compare against
    // With nothing selected every later sample hits
    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            edge_hit <= 1'b0;
        end
        else
        begin
            edge_hit <= sample_valid && have_prev && (&agree);
        end
    end

endmodule

/* hdl/pattern_trigger.sv */
`timescale 1ns/1ps

module pattern_trigger
    import la_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 8
)
(
    input  logic                    clock,
    input  logic                    arm,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample_data,
    input  logic [SAMPLE_WIDTH-1:0] pattern_value,
    input  logic [SAMPLE_WIDTH-1:0] pattern_care,
    output logic                    pattern_hit
);

    // Per-channel match under the care mask
    logic [SAMPLE_WIDTH-1:0] match;

    //////////////////////////////////////////////////////////////////////////////
    // Masked comparison
    //////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < SAMPLE_WIDTH; i++)
        begin
            match[i] = pattern_bit_match(pattern_care[i], pattern_value[i],
                                         sample_data[i]);
        end
    end

    // Registered so the hit lands on the same cycle as the edge hit
    // An all-zero care mask makes every valid sample a hit
    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            pattern_hit <= 1'b0;
        end
        else
        begin
            // Hit lasts one cycle per judged sample
            pattern_hit <= sample_valid && (&match);
        end
    end

endmodule

/* hdl/capture_control.sv */
`timescale 1ns/1ps

module capture_control
    import la_pkg::*;
#(
    parameter int SAMPLE_WIDTH  = 8,
    parameter int CAPTURE_DEPTH = 16
)
(
    input  logic                    clock,
    input  logic                    arm,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample_data,
    input  trig_mode_t              trig_mode,
    input  logic                    edge_hit,
    input  logic                    pattern_hit,
    output logic                    capture_valid,
    output logic [SAMPLE_WIDTH-1:0] capture_data,
    output logic                    triggered,
    output logic                    done
);

    // Counter holds 0 up to CAPTURE_DEPTH
    localparam int CNT_W = $clog2(CAPTURE_DEPTH + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CAPTURE_DEPTH - 1);

    // FSM encoding
    localparam logic [1:0] ST_SEARCH   = 2'd0;
    localparam logic [1:0] ST_CAPTURE  = 2'd1;
    localparam logic [1:0] ST_FINISHED = 2'd2;

    logic [1:0]              state;
    logic [CNT_W-1:0]        count;
    // Sample stream delayed to line up with the trigger hits
    logic                    valid_d;
    logic [SAMPLE_WIDTH-1:0] data_d;
    logic                    qualify;
    logic                    forward;
    logic                    last_forward;

    //////////////////////////////////////////////////////////////////////////////
    // Alignment
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            valid_d <= 1'b0;
        end
        else
        begin
            valid_d <= sample_valid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (sample_valid)
        begin
            data_d <= sample_data;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Trigger condition
    //////////////////////////////////////////////////////////////////////////////

    // Both hits refer to the sample now held in data_d
    always_comb
    begin
        case (trig_mode)
            TRIG_EDGE:    qualify = edge_hit;
            TRIG_PATTERN: qualify = pattern_hit;
            TRIG_BOTH:    qualify = edge_hit && pattern_hit;
            TRIG_EITHER:  qualify = edge_hit || pattern_hit;
            default:      qualify = 1'b0;
        endcase
    end

    // Trigger sample while searching, then every aligned sample
    assign forward = valid_d &&
                     (((state == ST_SEARCH) && qualify) || (state == ST_CAPTURE));
    // Count still shows the samples sent before this one
    assign last_forward = (count == LAST_COUNT);

    //////////////////////////////////////////////////////////////////////////////
    // Capture FSM
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            state         <= ST_SEARCH;
            count         <= '0;
            capture_valid <= 1'b0;
            triggered     <= 1'b0;
            done          <= 1'b0;
        end
        else
        begin
            capture_valid <= forward;
            // Done rides on the last forwarded sample
            done <= forward && last_forward;
            if (forward)
            begin
                count <= count + CNT_W'(1);
            end
            case (state)
                ST_SEARCH:
                begin
                    if (forward)
                    begin
                        triggered <= 1'b1;
                        // A depth of one finishes on the trigger sample
                        state <= last_forward ? ST_FINISHED : ST_CAPTURE;
                    end
                end
                ST_CAPTURE:
                begin
                    if (forward && last_forward)
                    begin
                        state <= ST_FINISHED;
                    end
                end
                ST_FINISHED:
                begin
                    // Stays here, deaf to input, until the next arm
                    triggered <= 1'b0;
                end
                default:
                begin
                    state <= ST_SEARCH;
                end
            endcase
        end
    end

    // Output payload, loaded only when a sample is sent
    always_ff @(posedge clock)
    begin
        if (forward)
        begin
            capture_data <= data_d;
        end
    end

endmodule

/* hdl/la_trigger_top.sv */
`timescale 1ns/1ps

module la_trigger_top
    import la_pkg::*;
#(
    parameter int SAMPLE_WIDTH  = 8,
    parameter int CAPTURE_DEPTH = 16
)
(
    input  logic                    clock,
    // Arm doubles as the asynchronous reset
    input  logic                    arm,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample_data,
    // Configuration, held steady from arm until done
    input  logic [SAMPLE_WIDTH-1:0] rise_select,
    input  logic [SAMPLE_WIDTH-1:0] fall_select,
    input  logic [SAMPLE_WIDTH-1:0] pattern_value,
    input  logic [SAMPLE_WIDTH-1:0] pattern_care,
    input  trig_mode_t              trig_mode,
    output logic                    capture_valid,
    output logic [SAMPLE_WIDTH-1:0] capture_data,
    output logic                    triggered,
    output logic                    done
);

    // Registered hits, one cycle behind the sample strobe
    logic edge_hit;
    logic pattern_hit;

    //////////////////////////////////////////////////////////////////////////////
    // Trigger units
    //////////////////////////////////////////////////////////////////////////////

    edge_trigger #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) edge_trigger0 (
        .clock        (clock),
        .arm          (arm),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .rise_select  (rise_select),
        .fall_select  (fall_select),
        .edge_hit     (edge_hit)
    );

    pattern_trigger #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) pattern_trigger0 (
        .clock         (clock),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .pattern_value (pattern_value),
        .pattern_care  (pattern_care),
        .pattern_hit   (pattern_hit)
    );

    //////////////////////////////////////////////////////////////////////////////
    // Capture controller
    //////////////////////////////////////////////////////////////////////////////

    // Sees the raw stream and aligns it to the hits itself
    capture_control #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH),
        .CAPTURE_DEPTH (CAPTURE_DEPTH)
    ) capture_control0 (
        .clock         (clock),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .trig_mode     (trig_mode),
        .edge_hit      (edge_hit),
        .pattern_hit   (pattern_hit),
        .capture_valid (capture_valid),
        .capture_data  (capture_data),
        .triggered     (triggered),
        .done          (done)
    );

endmodule

/* verif/la_trigger_properties.sv */
`timescale 1ns/1ps

module la_trigger_properties
(
    input logic clock,
    input logic arm,
    input logic sample_valid,
    input logic capture_valid,
    input logic triggered,
    input logic done
);

    // Set by done and held until the next arm
    logic finished;

    always_ff @(posedge clock or posedge arm)
    begin
        if (arm)
        begin
            finished <= 1'b0;
        end
        else if (done)
        begin
            finished <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output rules
    ////////////////////////////////////////////////////////////////////////////

    valid_while_triggered: assert property (@(posedge clock) disable iff (arm)
        capture_valid |-> triggered)
        else $error("capture_valid outside the capture window");

    // Done rides on the last forwarded sample and lasts one cycle
    done_with_sample: assert property (@(posedge clock) disable iff (arm)
        done |-> capture_valid ##1 !done)
        else $error("done not a single cycle with capture_valid");

    quiet_after_done: assert property (@(posedge clock) disable iff (arm)
        finished |-> !capture_valid && !done && !triggered)
        else $error("output activity between done and arm");

    // Each strobe seen while capturing returns on capture_valid two cycles later
    two_cycle_forward: assert property (@(posedge clock) disable iff (arm)
        $past(sample_valid) && triggered && !done |=> capture_valid)
        else $error("sample not forwarded two cycles after its strobe");

endmodule

/* verif/la_trigger_tb.sv */
`timescale 1ns/1ps

module la_trigger_tb
    import la_pkg::*;
();

    localparam int SAMPLE_WIDTH  = 8;
    localparam int CAPTURE_DEPTH = 16;
    localparam int NUM_TRIALS    = 48;
    // Cycles allowed to find a trigger and then to finish the window
    localparam int SEARCH_LIMIT  = 200;
    localparam int CAPTURE_LIMIT = 4 * CAPTURE_DEPTH + 20;
    localparam int POST_DONE     = 6;

    logic                    clock;
    logic                    arm;
    logic                    sample_valid;
    logic [SAMPLE_WIDTH-1:0] sample_data;
    logic [SAMPLE_WIDTH-1:0] rise_select;
    logic [SAMPLE_WIDTH-1:0] fall_select;
    logic [SAMPLE_WIDTH-1:0] pattern_value;
    logic [SAMPLE_WIDTH-1:0] pattern_care;
    trig_mode_t              trig_mode;
    logic                    capture_valid;
    logic [SAMPLE_WIDTH-1:0] capture_data;
    logic                    triggered;
    logic                    done;

    // Reference model state cleared on every arm
    logic [SAMPLE_WIDTH-1:0] expected_q[$];
    logic [SAMPLE_WIDTH-1:0] model_prev;
    logic                    model_have_prev;
    logic                    model_triggered;
    int                      model_count;
    // Monitor counters for the current trial
    int                      popped;
    int                      done_count;

    la_trigger_top #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH),
        .CAPTURE_DEPTH (CAPTURE_DEPTH)
    ) dut0 (
        .clock         (clock),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .rise_select   (rise_select),
        .fall_select   (fall_select),
        .pattern_value (pattern_value),
        .pattern_care  (pattern_care),
        .trig_mode     (trig_mode),
        .capture_valid (capture_valid),
        .capture_data  (capture_data),
        .triggered     (triggered),
        .done          (done)
    );

    bind la_trigger_top la_trigger_properties props0
    (
        .clock         (clock),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .capture_valid (capture_valid),
        .triggered     (triggered),
        .done          (done)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value
    (
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Selected channels need their edge and unselected channels pass
    function automatic logic edge_condition
    (
        input logic [SAMPLE_WIDTH-1:0] prev,
        input logic [SAMPLE_WIDTH-1:0] cur,
        input logic [SAMPLE_WIDTH-1:0] rise,
        input logic [SAMPLE_WIDTH-1:0] fall
    );
        return &(~(rise | fall) | (rise & ~prev & cur) | (fall & prev & ~cur));
    endfunction

    // Differences only count on cared bits
    function automatic logic pattern_condition
    (
        input logic [SAMPLE_WIDTH-1:0] cur,
        input logic [SAMPLE_WIDTH-1:0] value,
        input logic [SAMPLE_WIDTH-1:0] care
    );
        return ((cur ^ value) & care) == '0;
    endfunction

    function automatic logic mode_condition
    (
        input trig_mode_t mode,
        input logic       e,
        input logic       p
    );
        logic hit;
        case (mode)
            TRIG_EDGE:    hit = e;
            TRIG_PATTERN: hit = p;
            TRIG_BOTH:    hit = e && p;
            default:      hit = e || p;
        endcase
        return hit;
    endfunction

    // Judge one valid sample and queue it if it must be forwarded
    function automatic void model_sample(input logic [SAMPLE_WIDTH-1:0] data);
        logic e;
        logic p;
        // No predecessor right after arm
        e = model_have_prev && edge_condition(model_prev, data, rise_select, fall_select);
        p = pattern_condition(data, pattern_value, pattern_care);
        if (model_count < CAPTURE_DEPTH && (model_triggered || mode_condition(trig_mode, e, p)))
        begin
            model_triggered = 1'b1;
            expected_q.push_back(data);
            model_count++;
        end
        model_prev      = data;
        model_have_prev = 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Monitor
    ////////////////////////////////////////////////////////////////////////////

    // Registered outputs are settled at the falling edge
    always @(negedge clock)
    begin
        if (capture_valid)
        begin
            check_value("samples pending", 32'(expected_q.size() > 0), 32'd1);
            check_value("capture_data", 32'(capture_data), 32'(expected_q.pop_front()));
            check_value("triggered", 32'(triggered), 32'd1);
            popped++;
        end
        if (done)
        begin
            check_value("capture_valid at done", 32'(capture_valid), 32'd1);
            check_value("samples before done", popped, CAPTURE_DEPTH);
            check_value("earlier done pulses", done_count, 0);
            done_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic assert_arm();
        @(posedge clock);
        #1;
        arm          = 1'b1;
        sample_valid = 1'b0;
        expected_q.delete();
        model_have_prev = 1'b0;
        model_triggered = 1'b0;
        model_count     = 0;
        popped          = 0;
        done_count      = 0;
    endtask

    task automatic release_arm(input int cycles);
        repeat (cycles) @(posedge clock);
        #1;
        check_value("capture_valid in arm", 32'(capture_valid), 32'd0);
        check_value("triggered in arm", 32'(triggered), 32'd0);
        check_value("done in arm", 32'(done), 32'd0);
        arm = 1'b0;
    endtask

    // Sparse selects and care bits so triggers actually happen
    task automatic choose_config(input int trial);
        rise_select   = SAMPLE_WIDTH'($urandom & $urandom & $urandom);
        fall_select   = SAMPLE_WIDTH'($urandom & $urandom & $urandom);
        pattern_value = SAMPLE_WIDTH'($urandom);
        pattern_care  = SAMPLE_WIDTH'($urandom & $urandom & $urandom);
        // Either edge on the same channels
        if (trial % 8 == 3)
        begin
            fall_select = rise_select;
        end
        if (trial % 5 == 0)
        begin
            rise_select = '0;
            fall_select = '0;
        end
        if (trial % 4 == 1)
        begin
            pattern_care = '0;
        end
        trig_mode = trig_mode_t'(2'($urandom_range(3, 0)));
    endtask

    // Valid three times in four makes back to back runs common
    task automatic drive_cycle();
        logic                    v;
        logic [SAMPLE_WIDTH-1:0] d;
        v = ($urandom_range(3, 0) != 0);
        d = SAMPLE_WIDTH'($urandom);
        @(posedge clock);
        #1;
        sample_valid = v;
        sample_data  = d;
        if (v)
        begin
            model_sample(d);
        end
    endtask

    task automatic run_trial(input int trial);
        int search_cycles;
        int capture_cycles;
        bit abort;
        search_cycles  = 0;
        capture_cycles = 0;
        abort          = (trial % 6 == 5);
        assert_arm();
        choose_config(trial);
        release_arm(1);
        while (done_count == 0 && !(abort && popped >= 3) &&
               (model_triggered || search_cycles < SEARCH_LIMIT))
        begin
            if (model_triggered)
            begin
                if (capture_cycles >= CAPTURE_LIMIT)
                begin
                    $display("Timeout at %0t: done never followed the trigger", $time);
                    stop_with_failure();
                end
                capture_cycles++;
            end
            else
            begin
                search_cycles++;
            end
            drive_cycle();
        end
        if (done_count != 0)
        begin
            // Window closed so further samples must not be forwarded
            repeat (POST_DONE) drive_cycle();
            check_value("triggered after done", 32'(triggered), 32'd0);
        end
        else if (abort && popped >= 3)
        begin
            // Rearm in the middle of the window
            assert_arm();
            #1;
            check_value("triggered after rearm", 32'(triggered), 32'd0);
            check_value("capture_valid after rearm", 32'(capture_valid), 32'd0);
        end
        else
        begin
            @(posedge clock);
            #1;
            sample_valid = 1'b0;
            repeat (2) @(posedge clock);
            #1;
            check_value("triggered without trigger", 32'(triggered), 32'd0);
        end
    endtask

    initial
    begin
        void'($urandom(32'h888fd020));
        arm           = 1'b1;
        sample_valid  = 1'b0;
        sample_data   = '0;
        rise_select   = '0;
        fall_select   = '0;
        pattern_value = '0;
        pattern_care  = '0;
        trig_mode     = TRIG_EDGE;
        popped        = 0;
        done_count    = 0;
        release_arm(5);
        for (int trial = 0; trial < NUM_TRIALS; trial++)
        begin
            run_trial(trial);
        end
        $display("No errors");
        $finish;
    end

endmodule

/* files.f */
hdl/la_pkg.sv
hdl/edge_trigger.sv
hdl/pattern_trigger.sv
hdl/capture_control.sv
hdl/la_trigger_top.sv
verif/la_trigger_properties.sv
verif/la_trigger_tb.sv

/* Makefile */
# Verilator build for the logic analyzer trigger testbench
TOP := la_trigger_tb

.PHONY: all run lint clean

all: run

# Binary build with timing and assertions enabled
obj_dir/V$(TOP): files.f $(wildcard hdl/*.sv verif/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

# Exit status of the simulation is the pass or fail result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
